// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= setup_handler_tb
FILELIST  ?= setup_handler.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SEED_ARGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/buf_fill_counter.sv ====
`timescale 1ns/1ns
module buf_fill_counter
import setup_handler_pkg::*;
(
     input  logic                       clk
    ,input  logic                       ctrl_datap_reset_bytes_written

    ,input  logic                       clear_bytes
    ,input  logic                       incr_bytes

    ,output logic                       last_line
    ,output logic   [LINE_IDX_W-1:0]    line_idx
);

    logic   [BYTE_CNT_W-1:0]    bytes_reg;
    logic   [BYTE_CNT_W-1:0]    bytes_next;

    always_comb begin
        if (clear_bytes) begin
            bytes_next = '0;
        end
        else if (incr_bytes) begin
            bytes_next = bytes_reg + BYTE_STEP;
        end
        else begin
            bytes_next = bytes_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_datap_reset_bytes_written) begin
            bytes_reg <= '0;
        end
        else begin
            bytes_reg <= bytes_next;
        end
    end

    assign last_line = bytes_next >= BUF_BYTES_LIM;  // flags the line that fills the buffer.
    assign line_idx = {{(LINE_IDX_W-BYTE_CNT_W+DATA_BYTES_W){1'b0}},
                       bytes_reg[BYTE_CNT_W-1:DATA_BYTES_W]};

endmodule

// ==== logic/setup_ctrl.sv ====
`timescale 1ns/1ns
module setup_ctrl
import setup_handler_pkg::*;
(
     input  logic           clk
    ,input  logic           ctrl_datap_reset_bytes_written

    ,input  logic           setup_q_val
    ,input  logic           ptr_resp_val
    ,input  logic           rd_buf_resp_val
    ,input  logic           conn_q_val

    ,input  client_dir_e    hdr_dir
    ,input  logic           hdr_should_copy
    ,input  logic           last_conn
    ,input  logic           last_line

    ,output logic           store_flowid
    ,output logic           store_ptr
    ,output logic           store_hdr
    ,output logic           save_conn
    ,output logic           confirm
    ,output ptr_msg_e       ptr_mux_sel
    ,output logic           clear_bytes
    ,output logic           incr_bytes

    ,output logic           ptr_req_val
    ,output logic           rd_buf_req_val
    ,output logic           wr_buf_req_val
    ,output logic           app_mem_wr_val
    ,output logic           send_q_wr_val
    ,output logic           recv_q_wr_val
    ,output logic           busy
);

    setup_state_e   state_reg;
    setup_state_e   state_next;
    setup_state_e   post_copy_state;

    always_ff @(posedge clk) begin
        if (ctrl_datap_reset_bytes_written) begin
            state_reg <= ST_IDLE;
        end
        else begin
            state_reg <= state_next;
        end
    end

    assign busy = state_reg != ST_IDLE;

    // a client with no connections goes straight to the confirmation.
    always_comb begin
        if (hdr_dir == DIR_CLIENT) begin
            post_copy_state = last_conn ? ST_CONFIRM : ST_CLIENT_WAIT;
        end
        else begin
            post_copy_state = ST_SERVER_WR;
        end
    end

    always_comb begin
        state_next = state_reg;
        store_flowid = 1'b0;
        store_ptr = 1'b0;
        store_hdr = 1'b0;
        save_conn = 1'b0;
        confirm = 1'b0;
        ptr_mux_sel = PTR_MSG_REQ;
        clear_bytes = 1'b0;
        incr_bytes = 1'b0;
        ptr_req_val = 1'b0;
        rd_buf_req_val = 1'b0;
        wr_buf_req_val = 1'b0;
        app_mem_wr_val = 1'b0;
        send_q_wr_val = 1'b0;
        recv_q_wr_val = 1'b0;

        case (state_reg)
            ST_IDLE: begin
                if (setup_q_val) begin
                    store_flowid = 1'b1;
                    state_next = ST_PTR_REQ;
                end
            end
            ST_PTR_REQ: begin
                ptr_req_val = 1'b1;
                state_next = ST_WAIT_PTR;
            end
            ST_WAIT_PTR: begin
                if (ptr_resp_val) begin
                    store_ptr = 1'b1;
                    state_next = ST_RD_REQ;
                end
            end
            ST_RD_REQ: begin
                rd_buf_req_val = 1'b1;
                state_next = ST_WAIT_HDR;
            end
            ST_WAIT_HDR: begin
                if (rd_buf_resp_val) begin
                    store_hdr = 1'b1;
                    state_next = ST_PTR_ADJ;
                end
            end
            ST_PTR_ADJ: begin
                ptr_req_val = 1'b1;
                ptr_mux_sel = PTR_ADJUST;
                state_next = ST_APP_WR;
            end
            ST_APP_WR: begin
                app_mem_wr_val = 1'b1;
                clear_bytes = 1'b1;  // the fill always starts from line zero.
                state_next = hdr_should_copy ? ST_COPY : post_copy_state;
            end
            ST_COPY: begin
                wr_buf_req_val = 1'b1;
                incr_bytes = 1'b1;
                if (last_line) begin
                    state_next = post_copy_state;
                end
            end
            ST_CLIENT_WAIT: begin
                if (conn_q_val) begin
                    save_conn = 1'b1;
                    state_next = ST_CLIENT_WR;
                end
            end
            ST_CLIENT_WR: begin
                send_q_wr_val = 1'b1;
                recv_q_wr_val = 1'b1;
                if (last_conn) begin
                    state_next = ST_CONFIRM;
                end
                else if (conn_q_val) begin
                    save_conn = 1'b1;  // back to back connections stay here.
                end
                else begin
                    state_next = ST_CLIENT_WAIT;
                end
            end
            ST_SERVER_WR: begin
                recv_q_wr_val = 1'b1;
                state_next = ST_CONFIRM;
            end
            ST_CONFIRM: begin
                send_q_wr_val = 1'b1;
                confirm = 1'b1;
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

endmodule

// ==== logic/setup_datap.sv ====
`timescale 1ns/1ns
module setup_datap
import setup_handler_pkg::*;
(
     input  logic                       clk
    ,input  logic                       ctrl_datap_reset_bytes_written

    ,input  logic                       store_flowid
    ,input  logic                       store_ptr
    ,input  logic                       store_hdr
    ,input  logic                       save_conn
    ,input  logic                       confirm
    ,input  ptr_msg_e                   ptr_mux_sel

    ,input  logic   [FLOWID_W-1:0]      setup_q_flowid
    ,input  logic   [FLOWID_W-1:0]      conn_q_flowid
    ,input  logic   [BUF_PTR_W-1:0]     ptr_resp_head_ptr
    ,input  setup_hdr_t                 rd_buf_resp_data
    ,input  logic   [LINE_IDX_W-1:0]    line_idx

    ,output ptr_req_t                   ptr_req
    ,output buf_rd_req_t                rd_buf_req
    ,output buf_wr_req_t                wr_buf_req
    ,output logic   [FLOWID_W-1:0]      app_mem_wr_addr
    ,output app_cntxt_t                 app_mem_wr_data
    ,output send_q_t                    send_q_wr_data
    ,output logic   [FLOWID_W-1:0]      recv_q_wr_flowid

    ,output client_dir_e                hdr_dir
    ,output logic                       hdr_should_copy
    ,output logic                       last_conn
);

    logic   [FLOWID_W-1:0]      flowid_reg;
    logic   [FLOWID_W-1:0]      conn_flowid_reg;
    logic   [BUF_PTR_W-1:0]     head_ptr_reg;
    setup_hdr_t                 hdr_reg;
    logic   [CONN_CNT_W-1:0]    conn_cnt_reg;

    always_ff @(posedge clk) begin
        if (ctrl_datap_reset_bytes_written) begin
            conn_cnt_reg <= '0;
        end
        else if (store_flowid) begin
            conn_cnt_reg <= '0;
        end
        else if (save_conn) begin
            conn_cnt_reg <= conn_cnt_reg + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_flowid) begin
            flowid_reg <= setup_q_flowid;
        end
        if (save_conn) begin
            conn_flowid_reg <= conn_q_flowid;
        end
        if (store_ptr) begin
            head_ptr_reg <= ptr_resp_head_ptr;
        end
        if (store_hdr) begin
            hdr_reg <= rd_buf_resp_data;
        end
    end

    assign hdr_dir = hdr_reg.dir;
    assign hdr_should_copy = hdr_reg.should_copy;
    assign last_conn = conn_cnt_reg == hdr_reg.num_conns;

    always_comb begin
        ptr_req.msg_type = ptr_mux_sel;
        ptr_req.flowid = flowid_reg;
        if (ptr_mux_sel == PTR_ADJUST) begin
            ptr_req.head_ptr = head_ptr_reg + HDR_BYTES_PTR;  // skip past the setup header.
        end
        else begin
            ptr_req.head_ptr = '0;
        end
    end

    assign rd_buf_req.flowid = flowid_reg;
    assign rd_buf_req.offset = head_ptr_reg;
    assign rd_buf_req.size = HDR_BYTES_PTR;

    // each fill line carries its own index so the far side can check ordering.
    assign wr_buf_req.flowid = flowid_reg;
    assign wr_buf_req.offset = {line_idx[BUF_PTR_W-DATA_BYTES_W-1:0], {DATA_BYTES_W{1'b0}}};
    assign wr_buf_req.data = {LINE_REPS{line_idx}};

    assign app_mem_wr_addr = flowid_reg;

    always_comb begin
        app_mem_wr_data.total_reqs = hdr_reg.num_reqs;
        app_mem_wr_data.curr_reqs = '0;
        app_mem_wr_data.bufsize = hdr_reg.bufsize;
        app_mem_wr_data.should_copy = hdr_reg.should_copy;
    end

    always_comb begin
        if (confirm) begin
            send_q_wr_data.cmd = CMD_CTRL_RESP;
            send_q_wr_data.flowid = flowid_reg;
        end
        else begin
            send_q_wr_data.cmd = CMD_BENCH;
            send_q_wr_data.flowid = conn_flowid_reg;
        end
    end

    // a server registers the setup flow itself with the receive loop.
    assign recv_q_wr_flowid = (hdr_reg.dir == DIR_CLIENT) ? conn_flowid_reg : flowid_reg;

endmodule

// ==== logic/setup_handler_pkg.sv ====
package setup_handler_pkg;

    localparam FLOWID_W        = 8;
    localparam BUF_PTR_W       = 16;
    localparam DATA_W          = 64;
    localparam DATA_BYTES      = DATA_W / 8;
    localparam DATA_BYTES_W    = $clog2(DATA_BYTES);
    localparam TX_BUF_BYTES    = 64;
    localparam LINES_PER_BUF   = TX_BUF_BYTES / DATA_BYTES;
    localparam SETUP_HDR_BYTES = 8;
    localparam LINE_IDX_W      = 16;
    localparam LINE_REPS       = DATA_W / LINE_IDX_W;
    localparam CONN_CNT_W      = 8;
    localparam REQ_CNT_W       = 16;
    localparam BUFSIZE_W       = 16;
    localparam BYTE_CNT_W      = $clog2(TX_BUF_BYTES) + 1;  // one extra bit so a full buffer fits.

    localparam logic [BYTE_CNT_W-1:0] BYTE_STEP     = DATA_BYTES[BYTE_CNT_W-1:0];
    localparam logic [BYTE_CNT_W-1:0] BUF_BYTES_LIM = TX_BUF_BYTES[BYTE_CNT_W-1:0];
    localparam logic [BUF_PTR_W-1:0]  HDR_BYTES_PTR = SETUP_HDR_BYTES[BUF_PTR_W-1:0];

    typedef enum logic {
        DIR_SERVER,
        DIR_CLIENT
    } client_dir_e;

    typedef enum logic {
        PTR_MSG_REQ,
        PTR_ADJUST
    } ptr_msg_e;

    typedef enum logic {
        CMD_BENCH,
        CMD_CTRL_RESP
    } send_cmd_e;

    typedef struct packed {
        logic   [CONN_CNT_W-1:0]    num_conns;
        logic   [REQ_CNT_W-1:0]     num_reqs;
        logic   [BUFSIZE_W-1:0]     bufsize;
        logic                       should_copy;
        client_dir_e                dir;
        logic   [21:0]              padding;
    } setup_hdr_t;

    typedef struct packed {
        logic   [REQ_CNT_W-1:0]     total_reqs;
        logic   [REQ_CNT_W-1:0]     curr_reqs;
        logic   [BUFSIZE_W-1:0]     bufsize;
        logic                       should_copy;
    } app_cntxt_t;

    typedef struct packed {
        ptr_msg_e                   msg_type;
        logic   [FLOWID_W-1:0]      flowid;
        logic   [BUF_PTR_W-1:0]     head_ptr;
    } ptr_req_t;

    typedef struct packed {
        logic   [FLOWID_W-1:0]      flowid;
        logic   [BUF_PTR_W-1:0]     offset;
        logic   [BUF_PTR_W-1:0]     size;
    } buf_rd_req_t;

    typedef struct packed {
        logic   [FLOWID_W-1:0]      flowid;
        logic   [BUF_PTR_W-1:0]     offset;
        logic   [DATA_W-1:0]        data;
    } buf_wr_req_t;

    typedef struct packed {
        send_cmd_e                  cmd;
        logic   [FLOWID_W-1:0]      flowid;
    } send_q_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_PTR_REQ,
        ST_WAIT_PTR,
        ST_RD_REQ,
        ST_WAIT_HDR,
        ST_PTR_ADJ,
        ST_APP_WR,
        ST_COPY,
        ST_CLIENT_WAIT,
        ST_CLIENT_WR,
        ST_SERVER_WR,
        ST_CONFIRM
    } setup_state_e;

endpackage

// ==== logic/setup_handler_top.sv ====
`timescale 1ns/1ns
module setup_handler_top
import setup_handler_pkg::*;
(
     input  logic                       clk
    ,input  logic                       ctrl_datap_reset_bytes_written

    ,input  logic                       setup_q_val
    ,input  logic   [FLOWID_W-1:0]      setup_q_flowid
    ,input  logic                       ptr_resp_val
    ,input  logic   [BUF_PTR_W-1:0]     ptr_resp_head_ptr
    ,input  logic                       rd_buf_resp_val
    ,input  setup_hdr_t                 rd_buf_resp_data
    ,input  logic                       conn_q_val
    ,input  logic   [FLOWID_W-1:0]      conn_q_flowid

    ,output logic                       ptr_req_val
    ,output ptr_req_t                   ptr_req
    ,output logic                       rd_buf_req_val
    ,output buf_rd_req_t                rd_buf_req
    ,output logic                       wr_buf_req_val
    ,output buf_wr_req_t                wr_buf_req
    ,output logic                       app_mem_wr_val
    ,output logic   [FLOWID_W-1:0]      app_mem_wr_addr
    ,output app_cntxt_t                 app_mem_wr_data
    ,output logic                       send_q_wr_val
    ,output send_q_t                    send_q_wr_data
    ,output logic                       recv_q_wr_val
    ,output logic   [FLOWID_W-1:0]      recv_q_wr_flowid
    ,output logic                       busy
);

    logic                       store_flowid;
    logic                       store_ptr;
    logic                       store_hdr;
    logic                       save_conn;
    logic                       confirm;
    ptr_msg_e                   ptr_mux_sel;
    logic                       clear_bytes;
    logic                       incr_bytes;
    client_dir_e                hdr_dir;
    logic                       hdr_should_copy;
    logic                       last_conn;
    logic                       last_line;
    logic   [LINE_IDX_W-1:0]    line_idx;

    setup_ctrl i_setup_ctrl (.*);

    setup_datap i_setup_datap (.*);

    buf_fill_counter i_buf_fill_counter (.*);

endmodule

// ==== setup_handler.f ====
logic/setup_handler_pkg.sv
logic/buf_fill_counter.sv
logic/setup_ctrl.sv
logic/setup_datap.sv
logic/setup_handler_top.sv
verif/tb_clock_gen.sv
verif/setup_handler_asserts.sv
verif/setup_handler_tb.sv

// ==== verif/setup_handler_asserts.sv ====
`timescale 1ns/1ns
module setup_handler_asserts
import setup_handler_pkg::*;
(
     input  logic           clk
    ,input  logic           ctrl_datap_reset_bytes_written
    ,input  logic           ptr_req_val
    ,input  logic           rd_buf_req_val
    ,input  logic           wr_buf_req_val
    ,input  logic           app_mem_wr_val
    ,input  logic           send_q_wr_val
    ,input  logic           recv_q_wr_val
    ,input  logic           busy
    ,input  setup_state_e   state
);

    int unsigned    fail_cnt = 0;
    logic           any_strobe;

    assign any_strobe = ptr_req_val | rd_buf_req_val | wr_buf_req_val | app_mem_wr_val
                      | send_q_wr_val | recv_q_wr_val;

    // the first reset edge only settles the state register.
    no_strobe_in_reset: assert property (@(posedge clk)
        ctrl_datap_reset_bytes_written ##1 ctrl_datap_reset_bytes_written |-> !any_strobe)
    else begin
        $error("output strobe while reset is held");
        fail_cnt++;
    end

    wr_only_in_copy: assert property (@(posedge clk) disable iff (ctrl_datap_reset_bytes_written)
        wr_buf_req_val |-> state == ST_COPY)
    else begin
        $error("buffer write outside the copy state");
        fail_cnt++;
    end

    strobes_exclusive: assert property (@(posedge clk) disable iff (ctrl_datap_reset_bytes_written)
        $onehot0({ptr_req_val, rd_buf_req_val, wr_buf_req_val, app_mem_wr_val,
                  send_q_wr_val | recv_q_wr_val}))
    else begin
        $error("more than one output strobe in a cycle");
        fail_cnt++;
    end

    idle_not_busy: assert property (@(posedge clk) disable iff (ctrl_datap_reset_bytes_written)
        state == ST_IDLE |-> !busy)
    else begin
        $error("busy is high in the idle state");
        fail_cnt++;
    end

endmodule

// ==== verif/setup_handler_tb.sv ====
`timescale 1ns/1ns
module setup_handler_tb
import setup_handler_pkg::*;
();

    localparam int NUM_SETUPS = 40;
    localparam int TIMEOUT_NS = (NUM_SETUPS * 200 + 1000) * 10;

    logic                       clk;
    logic                       ctrl_datap_reset_bytes_written;
    logic                       setup_q_val;
    logic   [FLOWID_W-1:0]      setup_q_flowid;
    logic                       ptr_resp_val;
    logic   [BUF_PTR_W-1:0]     ptr_resp_head_ptr;
    logic                       rd_buf_resp_val;
    setup_hdr_t                 rd_buf_resp_data;
    logic                       conn_q_val;
    logic   [FLOWID_W-1:0]      conn_q_flowid;
    logic                       ptr_req_val;
    ptr_req_t                   ptr_req;
    logic                       rd_buf_req_val;
    buf_rd_req_t                rd_buf_req;
    logic                       wr_buf_req_val;
    buf_wr_req_t                wr_buf_req;
    logic                       app_mem_wr_val;
    logic   [FLOWID_W-1:0]      app_mem_wr_addr;
    app_cntxt_t                 app_mem_wr_data;
    logic                       send_q_wr_val;
    send_q_t                    send_q_wr_data;
    logic                       recv_q_wr_val;
    logic   [FLOWID_W-1:0]      recv_q_wr_flowid;
    logic                       busy;

    ptr_req_t                   exp_ptr_q[$];
    buf_rd_req_t                exp_rd_q[$];
    buf_wr_req_t                exp_wr_q[$];
    app_cntxt_t                 exp_app_q[$];
    logic   [FLOWID_W-1:0]      exp_app_addr_q[$];
    send_q_t                    exp_send_q[$];
    logic   [FLOWID_W-1:0]      exp_recv_q[$];
    int                         mismatch_cnt = 0;
    int                         other_err_cnt = 0;
    int                         total_errs;
    int                         cycle_cnt = 0;
    int                         last_wr_cycle = 0;
    int                         wr_run = 0;
    logic   [31:0]              seed_word;

    tb_clock_gen #(.PERIOD_NS(10)) i_tb_clock_gen (.clk(clk));

    setup_handler_top i_setup_handler_top (.*);

    bind setup_handler_top setup_handler_asserts i_setup_handler_asserts (
        .*, .state(i_setup_ctrl.state_reg));

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        other_err_cnt++;
    endtask

    task automatic check_ptr_req(input ptr_req_t exp, input ptr_req_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: ptr_req expected %h actual %h", $time, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_rd_req(input buf_rd_req_t exp, input buf_rd_req_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: rd_buf_req expected %h actual %h", $time, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_wr_req(input buf_wr_req_t exp, input buf_wr_req_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: wr_buf_req expected %h actual %h", $time, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_app_cntxt(input logic [FLOWID_W-1:0] exp_addr, input app_cntxt_t exp,
                                   input logic [FLOWID_W-1:0] act_addr, input app_cntxt_t act);
        if (act_addr !== exp_addr) begin
            $display("MISMATCH at %0t: app_mem_wr_addr expected %h actual %h",
                     $time, exp_addr, act_addr);
            mismatch_cnt++;
        end
        if (act !== exp) begin
            $display("MISMATCH at %0t: app_mem_wr_data expected %h actual %h", $time, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_send_q(input send_q_t exp, input send_q_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: send_q_wr_data expected %h actual %h", $time, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_recv_flowid(input logic [FLOWID_W-1:0] exp,
                                     input logic [FLOWID_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: recv_q_wr_flowid expected %h actual %h", $time, exp, act);
            mismatch_cnt++;
        end
    endtask

    // outputs depend on registers only, so the falling edge sees them settled.
    always @(negedge clk) begin
        cycle_cnt++;
        if (!ctrl_datap_reset_bytes_written) begin
            if (ptr_req_val) begin
                if (exp_ptr_q.size() == 0)
                    report_error("pointer request that no setup asked for");
                else
                    check_ptr_req(exp_ptr_q.pop_front(), ptr_req);
            end
            if (rd_buf_req_val) begin
                if (exp_rd_q.size() == 0)
                    report_error("buffer read that no setup asked for");
                else
                    check_rd_req(exp_rd_q.pop_front(), rd_buf_req);
            end
            if (wr_buf_req_val) begin
                if (wr_run != 0 && cycle_cnt != last_wr_cycle + 1)
                    report_error("buffer fill writes are not on consecutive cycles");
                last_wr_cycle = cycle_cnt;
                wr_run = (wr_run + 1) % LINES_PER_BUF;
                if (exp_wr_q.size() == 0)
                    report_error("buffer write when no fill was requested");
                else
                    check_wr_req(exp_wr_q.pop_front(), wr_buf_req);
            end
            if (app_mem_wr_val) begin
                if (exp_app_q.size() == 0)
                    report_error("app context write that no setup asked for");
                else
                    check_app_cntxt(exp_app_addr_q.pop_front(), exp_app_q.pop_front(),
                                    app_mem_wr_addr, app_mem_wr_data);
            end
            if (send_q_wr_val) begin
                if (exp_send_q.size() == 0)
                    report_error("send queue write that no setup asked for");
                else
                    check_send_q(exp_send_q.pop_front(), send_q_wr_data);
            end
            if (recv_q_wr_val) begin
                if (exp_recv_q.size() == 0)
                    report_error("receive queue write that no setup asked for");
                else
                    check_recv_flowid(exp_recv_q.pop_front(), recv_q_wr_flowid);
            end
        end
    end

    task automatic run_setup();
        logic   [FLOWID_W-1:0]  flowid;
        logic   [BUF_PTR_W-1:0] head_ptr;
        logic   [FLOWID_W-1:0]  conn_ids[$];
        logic   [31:0]          rnd;
        setup_hdr_t             hdr;
        buf_wr_req_t            line;
        int                     ptr_delay;
        int                     hdr_delay;

        rnd = $urandom();
        flowid = rnd[7:0];
        head_ptr = rnd[31:16];
        rnd = $urandom();
        hdr.num_reqs = rnd[15:0];
        hdr.bufsize = rnd[31:16];
        rnd = $urandom();
        hdr.num_conns = CONN_CNT_W'($urandom_range(4, 0));
        hdr.should_copy = rnd[0];
        hdr.dir = client_dir_e'(rnd[1]);
        hdr.padding = rnd[31:10];
        ptr_delay = $urandom_range(5, 0);
        hdr_delay = $urandom_range(5, 0);

        exp_ptr_q.push_back(ptr_req_t'{PTR_MSG_REQ, flowid, BUF_PTR_W'(0)});
        exp_rd_q.push_back(buf_rd_req_t'{flowid, head_ptr, BUF_PTR_W'(SETUP_HDR_BYTES)});
        exp_ptr_q.push_back(ptr_req_t'{PTR_ADJUST, flowid,
                                       head_ptr + BUF_PTR_W'(SETUP_HDR_BYTES)});
        exp_app_addr_q.push_back(flowid);
        exp_app_q.push_back(app_cntxt_t'{hdr.num_reqs, REQ_CNT_W'(0), hdr.bufsize,
                                         hdr.should_copy});
        for (int k = 0; k < LINES_PER_BUF && hdr.should_copy; k++) begin
            line.flowid = flowid;
            line.offset = BUF_PTR_W'(k * DATA_BYTES);
            for (int r = 0; r < DATA_W / LINE_IDX_W; r++) begin
                line.data[r * LINE_IDX_W +: LINE_IDX_W] = LINE_IDX_W'(k);
            end
            exp_wr_q.push_back(line);
        end
        if (hdr.dir == DIR_CLIENT) begin
            for (int c = 0; c < int'(hdr.num_conns); c++) begin
                rnd = $urandom();
                conn_ids.push_back(rnd[7:0]);
                exp_send_q.push_back(send_q_t'{CMD_BENCH, rnd[7:0]});
                exp_recv_q.push_back(rnd[7:0]);
            end
        end
        else begin
            exp_recv_q.push_back(flowid);
        end
        exp_send_q.push_back(send_q_t'{CMD_CTRL_RESP, flowid});

        setup_q_val = 1'b1;
        setup_q_flowid = flowid;
        @(negedge clk);
        setup_q_val = 1'b0;
        if (busy !== 1'b1)
            report_error("busy did not rise after the setup request");
        if (ptr_req_val !== 1'b1)
            report_error("pointer request did not follow the setup request by one cycle");
        while (!ptr_req_val) @(negedge clk);
        @(negedge clk);
        setup_q_val = 1'b1;  // a second request while busy must be dropped.
        setup_q_flowid = ~flowid;
        repeat (ptr_delay) begin
            @(negedge clk);
            setup_q_val = 1'b0;
        end
        ptr_resp_val = 1'b1;
        ptr_resp_head_ptr = head_ptr;
        @(negedge clk);
        ptr_resp_val = 1'b0;
        setup_q_val = 1'b0;
        if (rd_buf_req_val !== 1'b1)
            report_error("buffer read did not follow the pointer response by one cycle");
        while (!rd_buf_req_val) @(negedge clk);
        repeat (hdr_delay + 1) @(negedge clk);
        rd_buf_resp_val = 1'b1;
        rd_buf_resp_data = hdr;
        @(negedge clk);
        rd_buf_resp_val = 1'b0;
        if (ptr_req_val !== 1'b1 || ptr_req.msg_type !== PTR_ADJUST)
            report_error("pointer adjust did not follow the header by one cycle");
        @(negedge clk);
        if (app_mem_wr_val !== 1'b1)
            report_error("app context write did not follow the pointer adjust by one cycle");
        while (!app_mem_wr_val) @(negedge clk);
        @(negedge clk);
        while (wr_buf_req_val) @(negedge clk);
        foreach (conn_ids[i]) begin
            repeat ($urandom_range(3, 0)) @(negedge clk);
            conn_q_val = 1'b1;
            conn_q_flowid = conn_ids[i];
            @(negedge clk);
            conn_q_val = 1'b0;
            if (send_q_wr_val !== 1'b1 || recv_q_wr_val !== 1'b1)
                report_error("queue writes did not follow the connection strobe by one cycle");
        end
        while (!(send_q_wr_val && send_q_wr_data.cmd == CMD_CTRL_RESP)) @(negedge clk);
        @(negedge clk);
        if (busy !== 1'b0)
            report_error("busy stayed high after the setup confirmation");
        if (exp_ptr_q.size() + exp_rd_q.size() + exp_wr_q.size() + exp_app_q.size() +
            exp_send_q.size() + exp_recv_q.size() != 0)
            report_error("setup finished with expected outputs still missing");
    endtask

    initial begin
        seed_word = $urandom(32'h785d5df8);
        ctrl_datap_reset_bytes_written = 1'b1;
        setup_q_val = 1'b0;
        setup_q_flowid = '0;
        ptr_resp_val = 1'b0;
        ptr_resp_head_ptr = '0;
        rd_buf_resp_val = 1'b0;
        rd_buf_resp_data = '0;
        conn_q_val = 1'b0;
        conn_q_flowid = '0;
        repeat (10) @(negedge clk);
        ctrl_datap_reset_bytes_written = 1'b0;
        repeat (2) @(negedge clk);
        repeat (NUM_SETUPS) run_setup();
        repeat (5) @(negedge clk);
        total_errs = mismatch_cnt + other_err_cnt +
                     i_setup_handler_top.i_setup_handler_asserts.fail_cnt;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_cnt, other_err_cnt,
                 i_setup_handler_top.i_setup_handler_asserts.fail_cnt);
        if (total_errs == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns
module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule
